/* hdl/flip_det_pkg.sv */
`default_nettype none

package flip_det_pkg;

    // ##############################
    // Default sizes
    // ##############################
    localparam int SEQ_LENGTH   = 3;                           // Residual samples per window.
    localparam int FP_DEPTH     = 3;                           // Decision bits per window.
    localparam int CHAN_LEN     = SEQ_LENGTH + FP_DEPTH - 1;   // Channel vector length.
    localparam int CP           = 2;                           // Main tap position.
    localparam int NUM_PATTERNS = 5;                           // Flip masks in the bank.
    localparam int NUM_CAND     = NUM_PATTERNS + 1;            // Baseline is candidate 0.
    localparam int CAND_IDX_W   = $clog2(NUM_CAND);

    // Masks 001, 010, 100, 011, 110; entry p is candidate p+1.
    localparam logic [NUM_PATTERNS-1:0][FP_DEPTH-1:0] DEFAULT_FLIP_PATTERNS =
        {3'b110, 3'b011, 3'b100, 3'b010, 3'b001};

    // ##############################
    // Widths
    // ##############################
    typedef logic signed [7:0]  sample_t;      // Received sample and residual.
    typedef logic signed [7:0]  tap_t;         // Channel entry.
    typedef logic signed [11:0] err_t;         // Error after flips, covers 127 + 3*2*128.
    typedef logic signed [23:0] square_t;      // Signed product of two errors.
    typedef logic        [23:0] energy_t;      // Sum of squared errors.
    typedef logic [CAND_IDX_W-1:0] cand_idx_t; // Candidate number.

    // ##############################
    // Pipeline items
    // ##############################
    typedef struct packed {
        sample_t [SEQ_LENGTH-1:0] samples;
        tap_t    [CHAN_LEN-1:0]   taps;
        logic    [FP_DEPTH-1:0]   bits;        // Tentative decisions, 1 is symbol -1.
    } det_item_t;

    typedef struct packed {
        sample_t [SEQ_LENGTH-1:0] resid;
        tap_t    [CHAN_LEN-1:0]   taps;
        logic    [FP_DEPTH-1:0]   bits;
    } resid_item_t;

    typedef struct packed {
        energy_t [NUM_CAND-1:0] energies;
        logic    [FP_DEPTH-1:0] bits;
    } energy_item_t;

    typedef struct packed {
        logic [FP_DEPTH-1:0] bits;             // Refined decisions.
        cand_idx_t           idx;
        energy_t             energy;
    } det_result_t;

endpackage

`default_nettype wire

/* hdl/residual_calc.sv */
`default_nettype none

module residual_calc import flip_det_pkg::*; #(
    parameter int SEQ_LENGTH = flip_det_pkg::SEQ_LENGTH,
    parameter int FP_DEPTH   = flip_det_pkg::FP_DEPTH,
    parameter int CP         = flip_det_pkg::CP
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        in_valid,
    input  det_item_t   in_item,
    output logic        resid_valid,
    output resid_item_t resid_item
);

    localparam int   CH_LEN = SEQ_LENGTH + FP_DEPTH - 1;
    localparam err_t SAT_HI = err_t'(127);
    localparam err_t SAT_LO = err_t'(-128);

    sample_t [SEQ_LENGTH-1:0] resid_next;

    // ##############################
    // Channel rebuild and residual
    // ##############################
    always_comb begin
        err_t acc;
        err_t tap;
        int   idx;
        for (int ii = 0; ii < SEQ_LENGTH; ii++) begin
            acc = err_t'($signed(in_item.samples[ii]));
            for (int gi = 0; gi < FP_DEPTH; gi++) begin
                idx = CP - gi + ii;
                if (idx > 0 && idx < CH_LEN) begin               // Entry 0 never contributes.
                    tap = err_t'($signed(in_item.taps[idx]));
                    acc = in_item.bits[gi] ? acc + tap : acc - tap; // Symbol -1 adds the tap back.
                end
            end
            if (acc > SAT_HI) begin
                resid_next[ii] = sample_t'(SAT_HI);
            end else if (acc < SAT_LO) begin
                resid_next[ii] = sample_t'(SAT_LO);
            end else begin
                resid_next[ii] = sample_t'(acc);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            resid_valid <= 1'b0;
            resid_item  <= '0;
        end else begin
            resid_valid <= in_valid;
            if (in_valid) begin
                resid_item.resid <= resid_next;
                resid_item.taps  <= in_item.taps;                 // Stage 2 needs the taps again.
                resid_item.bits  <= in_item.bits;
            end
        end
    end

    a_in_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown(in_valid) && (!in_valid || !$isunknown(in_item))
    ) else $error("in_valid or the item it qualifies is unknown");

endmodule

`default_nettype wire

/* hdl/fp_checker.sv */
`default_nettype none

module fp_checker import flip_det_pkg::*; #(
    parameter int seq_length         = flip_det_pkg::SEQ_LENGTH,
    parameter int flip_pattern_depth = flip_det_pkg::FP_DEPTH,
    parameter int cp                 = flip_det_pkg::CP,
    parameter logic [flip_pattern_depth-1:0] flip_pattern = '0
) (
    input  sample_t [seq_length-1:0]                    seq,
    input  logic    [flip_pattern_depth-1:0]            bits,
    input  tap_t    [seq_length+flip_pattern_depth-2:0] channel,
    output energy_t                                     mse_val
);

    localparam int chan_len = seq_length + flip_pattern_depth - 1;

    err_t error [seq_length];

    // ##############################
    // Error after flipping
    // ##############################
    always_comb begin
        err_t step;
        int   idx;
        for (int ii = 0; ii < seq_length; ii++) begin
            error[ii] = err_t'($signed(seq[ii]));
            for (int gi = 0; gi < flip_pattern_depth; gi++) begin
                idx = cp - gi + ii;
                if (flip_pattern[gi] && idx > 0 && idx < chan_len) begin
                    step = err_t'($signed(channel[idx]));
                    step = step <<< 1;                           // Symbol swing is two.
                    error[ii] = bits[gi] ? error[ii] - step : error[ii] + step;
                end
            end
        end
    end

    // ##############################
    // Energy
    // ##############################
    always_comb begin
        square_t sq;
        mse_val = '0;
        for (int ii = 0; ii < seq_length; ii++) begin
            sq      = square_t'(error[ii]) * square_t'(error[ii]);
            mse_val = mse_val + energy_t'(sq);                   // Square is never negative.
        end
    end

endmodule

`default_nettype wire

/* hdl/pattern_bank.sv */
`default_nettype none

module pattern_bank import flip_det_pkg::*; #(
    parameter int SEQ_LENGTH   = flip_det_pkg::SEQ_LENGTH,
    parameter int FP_DEPTH     = flip_det_pkg::FP_DEPTH,
    parameter int CP           = flip_det_pkg::CP,
    parameter int NUM_PATTERNS = flip_det_pkg::NUM_PATTERNS,
    parameter logic [NUM_PATTERNS-1:0][FP_DEPTH-1:0] FLIP_PATTERNS = DEFAULT_FLIP_PATTERNS
) (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         resid_valid,
    input  resid_item_t  resid_item,
    output logic         en_valid,
    output energy_item_t en_item
);

    energy_t [NUM_PATTERNS:0] cand_energy;

    // ##############################
    // Candidate energies
    // ##############################

    // An empty mask gives the plain sum of squared residuals.
    fp_checker #(
        .seq_length         (SEQ_LENGTH),
        .flip_pattern_depth (FP_DEPTH),
        .cp                 (CP),
        .flip_pattern       ('0)
    ) u_baseline (
        .seq     (resid_item.resid),
        .bits    (resid_item.bits),
        .channel (resid_item.taps),
        .mse_val (cand_energy[0])
    );

    for (genvar p = 0; p < NUM_PATTERNS; p++) begin : g_pattern
        fp_checker #(
            .seq_length         (SEQ_LENGTH),
            .flip_pattern_depth (FP_DEPTH),
            .cp                 (CP),
            .flip_pattern       (FLIP_PATTERNS[p])
        ) u_checker (
            .seq     (resid_item.resid),
            .bits    (resid_item.bits),
            .channel (resid_item.taps),
            .mse_val (cand_energy[p+1])                          // Pattern p is candidate p+1.
        );
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            en_valid <= 1'b0;
            en_item  <= '0;
        end else begin
            en_valid <= resid_valid;
            if (resid_valid) begin
                en_item.energies <= cand_energy;
                en_item.bits     <= resid_item.bits;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/min_energy_select.sv */
`default_nettype none

module min_energy_select import flip_det_pkg::*; #(
    parameter int NUM_CAND = flip_det_pkg::NUM_CAND,
    parameter logic [NUM_CAND-2:0][FP_DEPTH-1:0] FLIP_PATTERNS = DEFAULT_FLIP_PATTERNS
) (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         en_valid,
    input  energy_item_t en_item,
    output logic         out_valid,
    output det_result_t  out_result
);

    energy_t             best_energy;
    cand_idx_t           best_idx;
    logic [FP_DEPTH-1:0] best_mask;

    // ##############################
    // Argmin
    // ##############################
    always_comb begin
        best_energy = en_item.energies[0];
        best_idx    = '0;
        best_mask   = '0;                                        // Baseline flips nothing.
        for (int c = 1; c < NUM_CAND; c++) begin
            if (en_item.energies[c] < best_energy) begin         // Strict compare keeps lowest index.
                best_energy = en_item.energies[c];
                best_idx    = cand_idx_t'(c);
                best_mask   = FLIP_PATTERNS[c-1];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid  <= 1'b0;
            out_result <= '0;
        end else begin
            out_valid <= en_valid;
            if (en_valid) begin
                out_result.bits   <= en_item.bits ^ best_mask;
                out_result.idx    <= best_idx;
                out_result.energy <= best_energy;
            end
        end
    end

    // ##############################
    // Checks
    // ##############################
    a_valid_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown(out_valid)
    ) else $error("out_valid is unknown");

endmodule

`default_nettype wire

/* hdl/flip_detector_top.sv */
`default_nettype none

module flip_detector_top import flip_det_pkg::*; #(
    parameter int SEQ_LENGTH   = flip_det_pkg::SEQ_LENGTH,
    parameter int FP_DEPTH     = flip_det_pkg::FP_DEPTH,
    parameter int CP           = flip_det_pkg::CP,
    parameter int NUM_PATTERNS = flip_det_pkg::NUM_PATTERNS,
    parameter logic [NUM_PATTERNS-1:0][FP_DEPTH-1:0] FLIP_PATTERNS = DEFAULT_FLIP_PATTERNS
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        in_valid,
    input  det_item_t   in_item,
    output logic        out_valid,
    output det_result_t out_result
);

    logic         resid_valid;
    resid_item_t  resid_item;
    logic         en_valid;
    energy_item_t en_item;

    residual_calc #(
        .SEQ_LENGTH (SEQ_LENGTH),
        .FP_DEPTH   (FP_DEPTH),
        .CP         (CP)
    ) u_residual_calc (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_item     (in_item),
        .resid_valid (resid_valid),
        .resid_item  (resid_item)
    );

    pattern_bank #(
        .SEQ_LENGTH    (SEQ_LENGTH),
        .FP_DEPTH      (FP_DEPTH),
        .CP            (CP),
        .NUM_PATTERNS  (NUM_PATTERNS),
        .FLIP_PATTERNS (FLIP_PATTERNS)
    ) u_pattern_bank (
        .clk         (clk),
        .rst_n       (rst_n),
        .resid_valid (resid_valid),
        .resid_item  (resid_item),
        .en_valid    (en_valid),
        .en_item     (en_item)
    );

    min_energy_select #(
        .NUM_CAND      (NUM_PATTERNS + 1),                       // Baseline plus the bank.
        .FLIP_PATTERNS (FLIP_PATTERNS)
    ) u_min_energy_select (
        .clk        (clk),
        .rst_n      (rst_n),
        .en_valid   (en_valid),
        .en_item    (en_item),
        .out_valid  (out_valid),
        .out_result (out_result)
    );

endmodule

`default_nettype wire

/* test/flip_det_checker.sv */
`default_nettype none

module flip_det_checker import flip_det_pkg::*; #(
    parameter int LATENCY = 3
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        in_valid,
    input  det_result_t exp_result,
    input  logic        out_valid,
    input  det_result_t out_result,
    output int          tests_passed,
    output int          tests_failed,
    output int          other_errors,
    output int          pending
);

    det_result_t want_q[$];
    int          due_q[$];
    int          num_q[$];
    int          cycle;
    int          next_num;

    // ##############################
    // Output compare
    // ##############################
    always @(posedge clk) begin
        det_result_t want;
        int          due;
        int          num;
        int          errs;
        if (!rst_n) begin
            cycle        = 0;
            next_num     = 1;
            tests_passed = 0;
            tests_failed = 0;
            other_errors = 0;
            pending      = 0;
            want_q.delete();
            due_q.delete();
            num_q.delete();
        end else begin
            cycle++;
            if (out_valid) begin
                if (want_q.size() == 0) begin
                    $display("Unexpected out_valid at cycle %0d with no test outstanding", cycle);
                    other_errors++;
                end else begin
                    want = want_q.pop_front();
                    due  = due_q.pop_front();
                    num  = num_q.pop_front();
                    errs = 0;
                    if (cycle != due) begin                          // Latency is fixed.
                        $display("Test %0d: result came out at cycle %0d instead of cycle %0d",
                                 num, cycle, due);
                        errs++;
                    end
                    if (out_result.bits !== want.bits) begin
                        $display("MISMATCH test %0d: out_result.bits expected %h actual %h",
                                 num, want.bits, out_result.bits);
                        errs++;
                    end
                    if (out_result.idx !== want.idx) begin
                        $display("MISMATCH test %0d: out_result.idx expected %h actual %h",
                                 num, want.idx, out_result.idx);
                        errs++;
                    end
                    if (out_result.energy !== want.energy) begin
                        $display("MISMATCH test %0d: out_result.energy expected %h actual %h",
                                 num, want.energy, out_result.energy);
                        errs++;
                    end
                    if (errs == 0) begin
                        tests_passed++;
                        $display("Test %0d passed: bits %b idx %0d energy %h",
                                 num, out_result.bits, out_result.idx, out_result.energy);
                    end else begin
                        tests_failed++;
                        $display("Test %0d failed", num);
                    end
                end
            end
            // New item seen this edge.
            if (in_valid) begin
                want_q.push_back(exp_result);
                due_q.push_back(cycle + LATENCY);
                num_q.push_back(next_num);
                next_num++;
            end
            pending = want_q.size();
        end
    end

endmodule

`default_nettype wire

/* test/tb_flip_detector.sv */
`default_nettype none

module tb_flip_detector import flip_det_pkg::*; ();

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 10;
    localparam int MAX_IDLE     = 2;                              // Idle cycles between items, 0..2.
    localparam int DRAIN_CYCLES = 10;

    logic        clk;
    logic        rst_n;
    logic        in_valid;
    det_item_t   in_item;
    logic        out_valid;
    det_result_t out_result;
    det_result_t exp_result;

    int          tests_passed;
    int          tests_failed;
    int          other_errors;
    int          pending;

    det_item_t   stim_q[$];
    det_result_t expect_q[$];
    bit          gap_q[$];
    int          num_tests;
    bit          loaded;
    bit          load_ok;
    integer      seed;

    always #(CLK_PERIOD/2) clk = ~clk;

    flip_detector_top DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_item    (in_item),
        .out_valid  (out_valid),
        .out_result (out_result)
    );

    flip_det_checker u_checker (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .exp_result   (exp_result),
        .out_valid    (out_valid),
        .out_result   (out_result),
        .tests_passed (tests_passed),
        .tests_failed (tests_failed),
        .other_errors (other_errors),
        .pending      (pending)
    );

    // ##############################
    // Test file
    // ##############################
    task automatic load_tests();
        integer              fd;
        integer              n;
        int                  line_no;
        string               line;
        logic [7:0]          y [SEQ_LENGTH];
        logic [7:0]          c [CHAN_LEN];
        logic [FP_DEPTH-1:0] bits_in;
        logic [FP_DEPTH-1:0] bits_exp;
        int                  idx_exp;
        logic [23:0]         energy_exp;
        int                  gap;
        det_item_t           item;
        det_result_t         res;
        fd      = $fopen("test/flip_det_tests.txt", "r");
        load_ok = 1'b0;
        if (fd == 0) begin
            $display("Cannot open the test file test/flip_det_tests.txt");
        end else begin
            load_ok = 1'b1;
            line_no = 0;
            while (!$feof(fd)) begin
                line = "";
                n    = $fgets(line, fd);
                line_no++;
                if (n > 0 && line.len() > 1 && line.getc(0) != "#") begin   // Skip notes and blanks.
                    n = $sscanf(line, "%h %h %h %h %h %h %h %h %b %b %d %h %d",
                                y[0], y[1], y[2], c[0], c[1], c[2], c[3], c[4],
                                bits_in, bits_exp, idx_exp, energy_exp, gap);
                    if (n != 13) begin
                        $display("Line %0d of the test file could not be read", line_no);
                        load_ok = 1'b0;
                    end else begin
                        for (int i = 0; i < SEQ_LENGTH; i++) begin
                            item.samples[i] = sample_t'(y[i]);
                        end
                        for (int k = 0; k < CHAN_LEN; k++) begin
                            item.taps[k] = tap_t'(c[k]);
                        end
                        item.bits  = bits_in;
                        res.bits   = bits_exp;
                        res.idx    = cand_idx_t'(idx_exp);
                        res.energy = energy_exp;
                        stim_q.push_back(item);
                        expect_q.push_back(res);
                        gap_q.push_back(gap != 0);
                    end
                end
            end
            $fclose(fd);
        end
        num_tests = stim_q.size();
        if (load_ok && num_tests == 0) begin
            $display("The test file holds no tests");
            load_ok = 1'b0;
        end
    endtask

    // ##############################
    // Stimulus
    // ##############################
    task automatic run_tests();
        int idle;
        for (int t = 0; t < num_tests; t++) begin
            if (gap_q[t]) begin
                idle = $unsigned($random(seed)) % (MAX_IDLE + 1);
                repeat (idle) begin
                    @(negedge clk);
                    in_valid = 1'b0;
                end
            end
            @(negedge clk);
            in_valid   = 1'b1;
            in_item    = stim_q[t];
            exp_result = expect_q[t];                                // Checker takes it with in_valid.
        end
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic drain_pipeline();
        int waited;
        waited = 0;
        while (pending != 0 && waited < DRAIN_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        repeat (4) @(negedge clk);                                   // Room for a stray out_valid.
    endtask

    initial begin
        seed       = 32'hbaa0_0c29;
        clk        = 1'b0;
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        in_item    = '0;
        exp_result = '0;
        num_tests  = 0;
        loaded     = 1'b0;
        load_tests();
        loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        if (load_ok) begin
            run_tests();
            drain_pipeline();
        end
        if (pending != 0) begin
            $display("%0d tests never produced a result", pending);
        end
        $display("Counts: %0d tests read, %0d passed, %0d failed, %0d other errors, %0d outstanding",
                 num_tests, tests_passed, tests_failed, other_errors, pending);
        if (load_ok && tests_failed == 0 && other_errors == 0 && pending == 0
            && tests_passed == num_tests) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // ##############################
    // Watchdog
    // ##############################
    initial begin
        int limit;
        wait (loaded);
        limit = (num_tests + 20) * CLK_PERIOD * 4;
        #(limit);
        $display("Timeout: the run did not finish within %0d time units", limit);
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

/* test/flip_det_tests.txt */
# Columns: y0 y1 y2  c0 c1 c2 c3 c4  bits  exp_bits exp_idx exp_energy  gap
# Samples, taps and energy in hex; bits as b2b1b0; gap 1 lets idle cycles come before the item.
# Tentative bits correct
0e 0e 0d 05 03 0a 02 01 000 000 0 000002 1
f9 07 f6 05 03 0a 02 01 101 101 0 000005 1
f1 f7 0a 05 03 0a 02 01 011 011 0 00000d 1
07 f5 f5 05 03 0a 02 01 110 110 0 000000 1
11 f5 04 7f fc 0c 05 fe 010 010 0 000002 1
# One wrong bit
0f 10 0d 05 03 0a 02 01 001 000 1 000005 1
07 fa 0a 05 03 0a 02 01 000 010 2 000002 1
0e 09 f7 05 03 0a 02 01 000 100 3 000005 1
f2 f0 f4 05 03 0a 02 01 110 111 1 000003 1
fc 0b 0b 05 03 0a 02 01 011 001 2 000009 1
f9 06 f8 05 03 0a 02 01 001 101 3 000002 1
10 ff ed 7f fc 0c 05 fe 010 110 3 000004 0
# Two adjacent wrong bits, back to back
0e 10 0e 05 03 0a 02 01 011 000 4 000003 1
05 f6 f5 05 03 0a 02 01 000 110 5 000005 0
f3 f7 09 05 03 0a 02 01 000 011 4 000004 0
0d 07 f8 05 03 0a 02 01 010 100 5 000005 0
ef 0c fc 7f fc 0c 05 fe 110 101 4 000003 0
# Equal energies
0d 0c 03 05 03 0a 02 01 000 000 0 00006d 0
0a 02 01 05 03 0a 02 01 000 010 2 00007a 0
# Saturated residuals
7f 7f 7f 05 03 0a 02 01 111 100 4 008a7b 1
80 80 80 05 03 0a 02 01 000 011 4 008d08 1
7f 00 00 05 03 0a 02 01 111 100 4 00285b 1

/* sim.f */
hdl/flip_det_pkg.sv
hdl/residual_calc.sv
hdl/fp_checker.sv
hdl/pattern_bank.sv
hdl/min_energy_select.sv
hdl/flip_detector_top.sv
test/flip_det_checker.sv
test/tb_flip_detector.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the flip detector testbench with Verilator.

cd "$(dirname "$0")" || exit 1

log=sim.log

if ! verilator --binary --assert --top-module tb_flip_detector -f sim.f; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_flip_detector > "$log" 2>&1
status=$?
cat "$log"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# The log decides pass or fail.
if grep -q "Done: errors found" "$log"; then
    echo "Simulation reported errors, see $log"
    exit 1
fi

echo "Simulation passed"
exit 0
